//--- bench/tb_io_subsystem.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tb_io_subsystem: random-stimulus testbench for the IO subsystem,
// checked against a register and scratch RAM model
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_io_subsystem;
	import io_pkg::*;

	logic                     CLK = 1'b0;
	logic                     RSTb;
	addr_t                    address;
	data_t                    data_in;
	logic                     mem_wr;
	data_t                    data_out;
	logic [GPIO_IN_BITS-1:0]  gpio_in;
	logic [GPIO_OUT_BITS-1:0] gpio_out;
	irq_vec_t                 irq;
	logic                     interrupt;

	logic [31:0]             rng_state = 32'h905e_5be0;
	logic [31:0]             rnd;
	data_t                   ram_model [RAM_DEPTH];
	bit                      ram_valid [RAM_DEPTH];
	ram_addr_t               written_q [$];
	ram_addr_t               picks [64];
	ram_addr_t               ra;
	data_t                   rd;
	data_t                   prev;
	data_t                   dummy;
	data_t                   reload;
	irq_vec_t                irq_seen;
	irq_vec_t                pend_exp;
	logic [GPIO_IN_BITS-1:0] pattern;
	logic [GPIO_IN_BITS-1:0] last_pattern;
	logic [GPIO_IN_BITS-1:0] mask;
	int                      i;

	// timer reload, ctrl, count, gpio out, in, mask, irq pending, enable
	addr_t mapped_regs [8] = '{
		{REGION_TIMER, 8'h00, TIMER_RELOAD},
		{REGION_TIMER, 8'h00, TIMER_CTRL},
		{REGION_TIMER, 8'h00, TIMER_COUNT},
		{REGION_GPIO, 8'h00, GPIO_OUT},
		{REGION_GPIO, 8'h00, GPIO_IN},
		{REGION_GPIO, 8'h00, GPIO_EDGE_MASK},
		{REGION_IRQ, 8'h00, IRQ_PENDING},
		{REGION_IRQ, 8'h00, IRQ_ENABLE}
	};
	data_t   shadow [8] = '{default: '0};	// expected read of each mapped_regs entry
	region_t unmapped_regions [12] = '{4'h0, 4'h2, 4'h3, 4'h4, 4'h5, 4'h6,
		4'hA, 4'hB, 4'hC, 4'hD, 4'hE, 4'hF};

	io_subsystem io_subsystem_inst (
		.CLK       (CLK),
		.RSTb      (RSTb),
		.address   (address),
		.data_in   (data_in),
		.mem_wr    (mem_wr),
		.data_out  (data_out),
		.gpio_in   (gpio_in),
		.gpio_out  (gpio_out),
		.irq       (irq),
		.interrupt (interrupt)
	);

	always #10 CLK = ~CLK;

	function automatic logic [31:0] xorshift32();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function automatic addr_t reg_addr(region_t r, reg_sel_t s);
		return {r, 8'h00, s};
	endfunction

	task automatic check_value(input data_t actual, input data_t expected, input string what);
		if (actual !== expected) begin
			$display("** Error at %0t ns: %s, expected %h, got %h", $time, what, expected, actual);
			$display("CHECKS FAILED");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	// every bus task starts and ends in the time step of a rising edge
	task automatic bus_write(input addr_t a, input data_t d, output data_t old);
		address <= a;
		data_in <= d;
		mem_wr  <= 1'b1;
		@(posedge CLK);	// write lands on this edge
		mem_wr <= 1'b0;
		@(negedge CLK);
		old = data_out;	// read side of the write cycle
		@(posedge CLK);
	endtask

	task automatic bus_read(input addr_t a, output data_t d);
		address <= a;
		mem_wr  <= 1'b0;
		@(posedge CLK);
		@(negedge CLK);
		d = data_out;
		@(posedge CLK);
	endtask

	task automatic check_registers(input string what);
		data_t val;
		for (int k = 0; k < 8; k++) begin
			bus_read(mapped_regs[k], val);
			check_value(val, shadow[k], what);
		end
	endtask

	task automatic wait_interrupt(input int limit, output irq_vec_t seen);
		logic got;
		got = 1'b0;
		for (int n = 0; n < limit && !got; n++) begin
			@(negedge CLK);
			if (interrupt) begin
				got  = 1'b1;
				seen = irq;
			end
		end
		if (!got) begin
			$display("Timeout: the interrupt never arrived within %0d cycles", limit);
			$display("CHECKS FAILED");
			$fatal(1, "interrupt wait timed out");
		end else begin
			@(posedge CLK);
		end
	endtask

	initial begin
		RSTb    = 1'b0;
		address = '0;
		data_in = '0;
		mem_wr  = 1'b0;
		gpio_in = '0;
		repeat (2) @(posedge CLK);
		RSTb <= 1'b1;

		// reset state
		@(negedge CLK);
		check_value(data_t'(irq), '0, "irq after reset");
		check_value(data_t'(interrupt), '0, "interrupt after reset");
		check_value(data_t'(gpio_out), '0, "gpio_out after reset");
		@(posedge CLK);
		check_registers("register read after reset");

		// address map
		rnd = xorshift32();
		bus_write(reg_addr(REGION_GPIO, GPIO_OUT), rnd[15:0], dummy);
		shadow[3] = data_t'(rnd[GPIO_OUT_BITS-1:0]);
		@(negedge CLK);
		check_value(data_t'(gpio_out), shadow[3], "gpio_out pins");
		@(posedge CLK);
		reload = rnd[31:16];
		bus_write(reg_addr(REGION_TIMER, TIMER_RELOAD), reload, dummy);
		shadow[0] = reload;
		shadow[2] = reload;	// count loads with the reload
		for (i = 0; i < 20; i++) begin
			rnd = xorshift32();
			bus_write({unmapped_regions[rnd[3:0] % 12], rnd[15:4]}, rnd[31:16], dummy);
		end
		check_registers("mapped register after unmapped writes");
		for (i = 0; i < 10; i++) begin
			rnd = xorshift32();
			bus_read({unmapped_regions[rnd[3:0] % 12], rnd[15:4]}, rd);
			check_value(rd, '0, "unmapped window read");
		end

		// scratch RAM, write cycle returns the old word
		for (i = 0; i < 200; i++) begin
			rnd = xorshift32();
			ra  = rnd[RAM_ADDR_W-1:0];
			bus_write({REGION_SCRATCH, rnd[27:25], ra}, rnd[31:16] ^ rnd[15:0], prev);
			if (ram_valid[ra])
				check_value(prev, ram_model[ra], "scratch old data on write");
			else
				written_q.push_back(ra);
			ram_model[ra] = rnd[31:16] ^ rnd[15:0];
			ram_valid[ra] = 1'b1;
			if (i % 8 == 0) begin
				bus_read({REGION_SCRATCH, 3'b000, ra}, rd);
				check_value(rd, ram_model[ra], "scratch read after write");
			end
		end
		for (i = 0; i < 64; i++)
			picks[i] = written_q[xorshift32() % written_q.size()];
		address <= {REGION_SCRATCH, 3'b000, picks[0]};
		for (i = 0; i < 64; i++) begin
			@(posedge CLK);
			if (i < 63)
				address <= {REGION_SCRATCH, 3'b000, picks[i+1]};	// one read per cycle
			@(negedge CLK);
			check_value(data_out, ram_model[picks[i]], "back-to-back scratch read");
		end
		@(posedge CLK);

		// timer events through the interrupt controller
		reload = data_t'(4 + xorshift32() % 37);
		bus_write(reg_addr(REGION_TIMER, TIMER_RELOAD), reload, dummy);
		bus_write(reg_addr(REGION_IRQ, IRQ_ENABLE), 16'h0001, dummy);
		bus_write(reg_addr(REGION_TIMER, TIMER_CTRL), 16'h0001, dummy);
		wait_interrupt(reload + 5, irq_seen);
		check_value(data_t'(irq_seen), 16'h0001, "irq on first timer event");
		bus_write(reg_addr(REGION_IRQ, IRQ_PENDING), 16'h0001, dummy);
		bus_read(reg_addr(REGION_IRQ, IRQ_PENDING), rd);
		check_value(rd, '0, "timer pending after clear");
		wait_interrupt(reload + 1, irq_seen);
		check_value(data_t'(irq_seen), 16'h0001, "irq on second timer event");

		// disabled source still latches pending
		bus_write(reg_addr(REGION_IRQ, IRQ_ENABLE), 16'h0000, dummy);
		bus_write(reg_addr(REGION_IRQ, IRQ_PENDING), 16'h0003, dummy);
		bus_write(reg_addr(REGION_TIMER, TIMER_RELOAD), 16'd4, dummy);
		for (i = 0; i < 20; i++) begin
			@(negedge CLK);
			check_value(data_t'({irq, interrupt}), '0, "irq with enable cleared");
		end
		@(posedge CLK);
		bus_read(reg_addr(REGION_IRQ, IRQ_PENDING), rd);
		check_value(rd, 16'h0001, "masked timer pending");
		bus_write(reg_addr(REGION_TIMER, TIMER_CTRL), 16'h0000, dummy);
		bus_write(reg_addr(REGION_IRQ, IRQ_PENDING), 16'h0003, dummy);
		bus_read(reg_addr(REGION_IRQ, IRQ_PENDING), rd);
		check_value(rd, '0, "pending after final clear");

		// GPIO rising edges under the mask
		rnd  = xorshift32();
		mask = rnd[GPIO_IN_BITS-1:0];
		bus_write(reg_addr(REGION_GPIO, GPIO_EDGE_MASK), data_t'(mask), dummy);
		last_pattern = '0;
		for (i = 0; i < 30; i++) begin
			rnd      = xorshift32();
			pattern  = rnd[GPIO_IN_BITS-1:0];
			gpio_in <= pattern;
			pend_exp = '0;
			pend_exp[IRQ_GPIO] = |(pattern & ~last_pattern & mask);
			repeat (4) @(posedge CLK);	// two sync flops, edge detect, pending
			bus_read(reg_addr(REGION_IRQ, IRQ_PENDING), rd);
			check_value(rd, data_t'(pend_exp), "gpio pending bit");
			bus_read(reg_addr(REGION_GPIO, GPIO_IN), rd);
			check_value(rd, data_t'(pattern), "GPIO_IN read");
			bus_write(reg_addr(REGION_IRQ, IRQ_PENDING), 16'h0002, dummy);
			last_pattern = pattern;
		end

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

//--- files.f
hw/io_pkg.sv
hw/port_controller.sv
hw/io_timer.sv
hw/io_gpio.sv
hw/interrupt_controller.sv
hw/scratch_ram.sv
hw/io_subsystem.sv
bench/tb_io_subsystem.sv

//--- hw/interrupt_controller.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// interrupt_controller: pending and enable registers for the timer
// and GPIO events, one registered CPU interrupt line
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module interrupt_controller (
	input  logic             CLK,
	input  logic             RSTb,
	input  io_pkg::io_req_t  req,
	input  logic             wr,
	output io_pkg::data_t    rdata,
	input  logic             timer_event,
	input  logic             gpio_event,
	output io_pkg::irq_vec_t irq,
	output logic             interrupt
);
	import io_pkg::*;

	reg_sel_t reg_sel;
	irq_vec_t events;
	irq_vec_t clear;
	irq_vec_t pending_q;
	irq_vec_t enable_q;

	assign reg_sel = req.addr[REG_SEL_W-1:0];

	always_comb begin
		events            = '0;
		events[IRQ_TIMER] = timer_event;
		events[IRQ_GPIO]  = gpio_event;
	end

	// write 1s to clear pending bits
	assign clear = (wr && reg_sel == IRQ_PENDING) ? req.wdata[IRQ_SOURCES-1:0] : '0;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			pending_q <= '0;
			enable_q  <= '0;
			interrupt <= 1'b0;
		end else begin
			pending_q <= (pending_q & ~clear) | events;	// set wins over clear
			if (wr && reg_sel == IRQ_ENABLE)
				enable_q <= req.wdata[IRQ_SOURCES-1:0];
			interrupt <= |irq;	// one cycle behind irq
		end
	end

	assign irq = pending_q & enable_q;

	always_comb begin
		case (reg_sel)
			IRQ_PENDING: rdata = data_t'(pending_q);
			IRQ_ENABLE:  rdata = data_t'(enable_q);
			default:     rdata = '0;
		endcase
	end

endmodule

//--- hw/io_gpio.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// io_gpio: output pins, synchronized inputs and masked
// rising-edge events
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module io_gpio (
	input  logic                              CLK,
	input  logic                              RSTb,
	input  io_pkg::io_req_t                   req,
	input  logic                              wr,
	output io_pkg::data_t                     rdata,
	input  logic [io_pkg::GPIO_IN_BITS-1:0]   gpio_in,
	output logic [io_pkg::GPIO_OUT_BITS-1:0]  gpio_out,
	output logic                              gpio_event
);
	import io_pkg::*;

	reg_sel_t                 reg_sel;
	logic [GPIO_IN_BITS-1:0]  sync1_q;
	logic [GPIO_IN_BITS-1:0]  sync2_q;
	logic [GPIO_IN_BITS-1:0]  prev_q;	// last synchronized sample
	logic [GPIO_IN_BITS-1:0]  mask_q;
	logic [GPIO_IN_BITS-1:0]  rising;

	assign reg_sel = req.addr[REG_SEL_W-1:0];

	// mask bit set means the pin can interrupt
	assign rising = sync2_q & ~prev_q & mask_q;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			sync1_q    <= '0;
			sync2_q    <= '0;
			prev_q     <= '0;
			mask_q     <= '0;
			gpio_out   <= '0;
			gpio_event <= 1'b0;
		end else begin
			sync1_q    <= gpio_in;
			sync2_q    <= sync1_q;
			prev_q     <= sync2_q;
			gpio_event <= |rising;	// third edge after the pin change
			if (wr && reg_sel == GPIO_OUT)
				gpio_out <= req.wdata[GPIO_OUT_BITS-1:0];
			if (wr && reg_sel == GPIO_EDGE_MASK)
				mask_q <= req.wdata[GPIO_IN_BITS-1:0];
		end
	end

	always_comb begin
		case (reg_sel)
			GPIO_OUT:       rdata = data_t'(gpio_out);
			GPIO_IN:        rdata = data_t'(sync2_q);
			GPIO_EDGE_MASK: rdata = data_t'(mask_q);
			default:        rdata = '0;
		endcase
	end

endmodule

//--- hw/io_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// io_pkg: shared widths, address map, register offsets and
// interrupt source indices of the IO port subsystem
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package io_pkg;

	localparam int DATA_W     = 16;
	localparam int ADDR_W     = 16;
	localparam int REGION_W   = 4;	// upper address nibble
	localparam int REG_SEL_W  = 4;
	localparam int RAM_ADDR_W = 9;
	localparam int RAM_DEPTH  = 512;

	typedef logic [DATA_W-1:0]     data_t;
	typedef logic [ADDR_W-1:0]     addr_t;
	typedef logic [REGION_W-1:0]   region_t;
	typedef logic [REG_SEL_W-1:0]  reg_sel_t;
	typedef logic [RAM_ADDR_W-1:0] ram_addr_t;

	typedef struct packed {
		addr_t addr;
		data_t wdata;
		logic  wr;
	} io_req_t;

	// address windows
	localparam region_t REGION_GPIO    = 4'h1;
	localparam region_t REGION_IRQ     = 4'h7;
	localparam region_t REGION_SCRATCH = 4'h8;
	localparam region_t REGION_TIMER   = 4'h9;

	localparam reg_sel_t TIMER_RELOAD = 4'd0;	// also loads the count
	localparam reg_sel_t TIMER_CTRL   = 4'd1;	// bit 0 enable
	localparam reg_sel_t TIMER_COUNT  = 4'd2;	// read only

	localparam reg_sel_t GPIO_OUT       = 4'd0;
	localparam reg_sel_t GPIO_IN        = 4'd1;
	localparam reg_sel_t GPIO_EDGE_MASK = 4'd2;

	localparam reg_sel_t IRQ_PENDING = 4'd0;	// write 1 to clear
	localparam reg_sel_t IRQ_ENABLE  = 4'd1;

	localparam int GPIO_IN_BITS  = 6;
	localparam int GPIO_OUT_BITS = 4;

	localparam int IRQ_SOURCES = 2;
	localparam int IRQ_TIMER   = 0;
	localparam int IRQ_GPIO    = 1;

	typedef logic [IRQ_SOURCES-1:0] irq_vec_t;

endpackage

//--- hw/io_subsystem.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// io_subsystem: port controller with timer, GPIO, interrupt
// controller and scratch pad RAM
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module io_subsystem (
	input  logic                             CLK,
	input  logic                             RSTb,
	input  io_pkg::addr_t                    address,
	input  io_pkg::data_t                    data_in,
	input  logic                             mem_wr,
	output io_pkg::data_t                    data_out,
	input  logic [io_pkg::GPIO_IN_BITS-1:0]  gpio_in,
	output logic [io_pkg::GPIO_OUT_BITS-1:0] gpio_out,
	output io_pkg::irq_vec_t                 irq,
	output logic                             interrupt
);
	import io_pkg::*;

	io_req_t req;
	logic    wr_timer;
	logic    wr_gpio;
	logic    wr_irq;
	logic    wr_ram;
	data_t   rdata_timer;
	data_t   rdata_gpio;
	data_t   rdata_irq;
	data_t   rdata_ram;
	logic    timer_event;
	logic    gpio_event;

	port_controller port_controller_inst (
		.CLK         (CLK),
		.RSTb        (RSTb),
		.address     (address),
		.data_in     (data_in),
		.mem_wr      (mem_wr),
		.req         (req),
		.wr_timer    (wr_timer),
		.wr_gpio     (wr_gpio),
		.wr_irq      (wr_irq),
		.wr_ram      (wr_ram),
		.rdata_timer (rdata_timer),
		.rdata_gpio  (rdata_gpio),
		.rdata_irq   (rdata_irq),
		.rdata_ram   (rdata_ram),
		.data_out    (data_out)
	);

	io_timer io_timer_inst (
		.CLK         (CLK),
		.RSTb        (RSTb),
		.req         (req),
		.wr          (wr_timer),
		.rdata       (rdata_timer),
		.timer_event (timer_event)
	);

	io_gpio io_gpio_inst (
		.CLK        (CLK),
		.RSTb       (RSTb),
		.req        (req),
		.wr         (wr_gpio),
		.rdata      (rdata_gpio),
		.gpio_in    (gpio_in),
		.gpio_out   (gpio_out),
		.gpio_event (gpio_event)
	);

	interrupt_controller interrupt_controller_inst (
		.CLK         (CLK),
		.RSTb        (RSTb),
		.req         (req),
		.wr          (wr_irq),
		.rdata       (rdata_irq),
		.timer_event (timer_event),
		.gpio_event  (gpio_event),
		.irq         (irq),
		.interrupt   (interrupt)
	);

	scratch_ram scratch_ram_inst (
		.CLK   (CLK),
		.addr  (req.addr[RAM_ADDR_W-1:0]),	// word address inside the window
		.wdata (req.wdata),
		.we    (wr_ram),
		.rdata (rdata_ram)
	);

endmodule

//--- hw/io_timer.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// io_timer: reloadable countdown timer, one event per period
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module io_timer (
	input  logic            CLK,
	input  logic            RSTb,
	input  io_pkg::io_req_t req,
	input  logic            wr,
	output io_pkg::data_t   rdata,
	output logic            timer_event
);
	import io_pkg::*;

	reg_sel_t reg_sel;
	data_t    reload_q;
	data_t    count_q;
	logic     enable_q;

	assign reg_sel = req.addr[REG_SEL_W-1:0];

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			reload_q    <= '0;
			count_q     <= '0;
			enable_q    <= 1'b0;
			timer_event <= 1'b0;
		end else begin
			timer_event <= 1'b0;
			if (wr && reg_sel == TIMER_RELOAD) begin
				reload_q <= req.wdata;
				count_q  <= req.wdata;	// restart from the new value
			end else if (enable_q) begin
				if (count_q == '0) begin
					count_q     <= reload_q;
					timer_event <= 1'b1;	// period is reload + 1
				end else begin
					count_q <= count_q - 1'b1;
				end
			end
			if (wr && reg_sel == TIMER_CTRL)
				enable_q <= req.wdata[0];
		end
	end

	// read word follows the current address
	always_comb begin
		case (reg_sel)
			TIMER_RELOAD: rdata = reload_q;
			TIMER_CTRL:   rdata = data_t'(enable_q);
			TIMER_COUNT:  rdata = count_q;
			default:      rdata = '0;
		endcase
	end

endmodule

//--- hw/port_controller.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// port_controller: decodes the upper address nibble into write
// strobes and returns read data through a registered read mux
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module port_controller (
	input  logic            CLK,
	input  logic            RSTb,
	input  io_pkg::addr_t   address,
	input  io_pkg::data_t   data_in,
	input  logic            mem_wr,
	output io_pkg::io_req_t req,
	output logic            wr_timer,
	output logic            wr_gpio,
	output logic            wr_irq,
	output logic            wr_ram,
	input  io_pkg::data_t   rdata_timer,
	input  io_pkg::data_t   rdata_gpio,
	input  io_pkg::data_t   rdata_irq,
	input  io_pkg::data_t   rdata_ram,
	output io_pkg::data_t   data_out
);
	import io_pkg::*;

	region_t region;
	region_t region_q;	// window of the read in flight
	data_t   dout_next;
	data_t   dout_q;

	// request forwarded to every block
	assign req.addr  = address;
	assign req.wdata = data_in;
	assign req.wr    = mem_wr;

	assign region = address[ADDR_W-1 -: REGION_W];

	always_comb begin
		wr_timer  = 1'b0;
		wr_gpio   = 1'b0;
		wr_irq    = 1'b0;
		wr_ram    = 1'b0;
		dout_next = '0;
		case (region)
			REGION_GPIO: begin
				wr_gpio   = mem_wr;
				dout_next = rdata_gpio;
			end
			REGION_IRQ: begin
				wr_irq    = mem_wr;
				dout_next = rdata_irq;
			end
			REGION_SCRATCH: begin
				wr_ram = mem_wr;	// ram registers its own read
			end
			REGION_TIMER: begin
				wr_timer  = mem_wr;
				dout_next = rdata_timer;
			end
			default: ;	// dropped peripherals, writes ignored
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			region_q <= '0;
		end else begin
			region_q <= region;
		end
	end

	always_ff @(posedge CLK) begin
		dout_q <= dout_next;
	end

	// registered nibble picks which registered word goes out
	always_comb begin
		case (region_q)
			REGION_GPIO, REGION_IRQ, REGION_TIMER: data_out = dout_q;
			REGION_SCRATCH:                        data_out = rdata_ram;
			default:                               data_out = '0;
		endcase
	end

endmodule

//--- hw/scratch_ram.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// scratch_ram: 512 x 16 single-port RAM, registered read
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module scratch_ram (
	input  logic              CLK,
	input  io_pkg::ram_addr_t addr,
	input  io_pkg::data_t     wdata,
	input  logic              we,
	output io_pkg::data_t     rdata
);
	import io_pkg::*;

	data_t mem [RAM_DEPTH];

	// read-first, same address write returns the old word
	always_ff @(posedge CLK) begin
		if (we)
			mem[addr] <= wdata;
		rdata <= mem[addr];
	end

endmodule
